//--- uart_rx.f
common/uart_rx_pkg.sv
hw/rx_baud_tick.sv
hw/rx_line_sampler.sv
rx_core/rx_frame_ctrl.sv
rx_core/rx_deserializer.sv
hw/rx_fifo.sv
hw/uart_rx_top.sv
test/tb_uart_rx.sv

//--- Bender.yml
package:
  name: uart_rx

sources:
  - common/uart_rx_pkg.sv
  - hw/rx_baud_tick.sv
  - hw/rx_line_sampler.sv
  - rx_core/rx_frame_ctrl.sv
  - rx_core/rx_deserializer.sv
  - hw/rx_fifo.sv
  - hw/uart_rx_top.sv
  - target: test
    files:
      - test/tb_uart_rx.sv

//--- test/tb_uart_rx.sv
`timescale 1ns/1ps

module tb_uart_rx;
	import uart_rx_pkg::*;

	localparam int BIT_CLKS   = TICK_DIV * OVERSAMPLE; // 160 clocks per serial bit.
	localparam int FRAME_CLKS = 10 * BIT_CLKS;
	localparam int WORD_WAIT  = 2 * FRAME_CLKS;
	localparam int GLITCH_CLKS = 40;
	// about 25 frames of traffic plus idle gaps and drains.
	localparam int TEST_FRAMES    = 25;
	localparam int TIMEOUT_CYCLES = TEST_FRAMES * FRAME_CLKS + 20000;

	logic     baud_rx_clock;
	logic     i_reset;
	logic     i_rx;
	logic     i_rx_ready;
	rx_word_t o_rx_word;
	logic     o_rx_valid;
	logic     o_overrun;

	int          pass_count = 0;
	int          fail_count = 0;
	int          cycles     = 0;
	logic [31:0] lfsr_state = 32'h26809041;

	uart_rx_top uart_rx_top_i (
		.baud_rx_clock (baud_rx_clock),
		.i_reset       (i_reset),
		.i_rx          (i_rx),
		.o_rx_word     (o_rx_word),
		.o_rx_valid    (o_rx_valid),
		.i_rx_ready    (i_rx_ready),
		.o_overrun     (o_overrun)
	);

	initial begin
		baud_rx_clock = 1'b0;
		forever #2 baud_rx_clock = ~baud_rx_clock;
	end

	always @(posedge baud_rx_clock) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks failed");
			$finish;
		end
	end

	// galois form, taps 32,22,2,1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			b[i]       = lfsr_state[0];
		end
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic drive_bit(input logic b);
		@(negedge baud_rx_clock);
		i_rx = b;
		repeat (BIT_CLKS - 1) @(negedge baud_rx_clock);
	endtask

	// start, eight data bits LSB first, stop, then back to idle.
	task automatic send_frame(input logic [7:0] data, input logic stop_value);
		drive_bit(1'b0);
		for (int i = 0; i < DATA_BITS; i++) begin
			drive_bit(data[i]);
		end
		drive_bit(stop_value);
		i_rx = 1'b1;
	endtask

	task automatic expect_word(input string name, input logic [7:0] data, input logic err);
		rx_word_t exp;
		int       waited;
		logic     prev_ready;
		exp.data        = data;
		exp.framing_err = err;
		waited          = 0;
		while (!o_rx_valid && waited < WORD_WAIT) begin
			@(negedge baud_rx_clock);
			waited++;
		end
		if (!o_rx_valid) begin
			$display("%s: no received word appeared within %0d cycles", name, WORD_WAIT);
			fail_count++;
		end else begin
			check_value(name, exp, o_rx_word);
			prev_ready = i_rx_ready;
			i_rx_ready = 1'b1; // one transfer.
			@(negedge baud_rx_clock);
			i_rx_ready = prev_ready;
		end
	endtask

	task automatic report_test(input string name, input int fails_before);
		if (fail_count == fails_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d failures", name, fail_count - fails_before);
	endtask

	task automatic single_byte();
		int fails_before;
		fails_before = fail_count;
		check_value("single_byte valid", 16'h0, o_rx_valid);
		check_value("single_byte overrun", 16'h0, o_overrun);
		send_frame(8'hA5, 1'b1);
		expect_word("single_byte", 8'hA5, 1'b0);
		report_test("single_byte", fails_before);
	endtask

	task automatic random_stream();
		logic [7:0] bytes [8];
		int         fails_before;
		fails_before = fail_count;
		for (int i = 0; i < 8; i++) begin
			random_byte(bytes[i]);
		end
		i_rx_ready = 1'b1;
		fork
			begin
				for (int i = 0; i < 8; i++) send_frame(bytes[i], 1'b1);
			end
			begin
				for (int i = 0; i < 8; i++) expect_word("random_stream", bytes[i], 1'b0);
			end
		join
		i_rx_ready = 1'b0;
		report_test("random_stream", fails_before);
	endtask

	task automatic framing_error();
		logic [7:0] good;
		int         fails_before;
		fails_before = fail_count;
		send_frame(8'h3C, 1'b0);
		drive_bit(1'b1);
		expect_word("framing_error", 8'h3C, 1'b1);
		random_byte(good);
		send_frame(good, 1'b1);
		expect_word("framing_error next", good, 1'b0);
		report_test("framing_error", fails_before);
	endtask

	task automatic glitch_reject();
		logic seen_valid;
		int   fails_before;
		fails_before = fail_count;
		seen_valid   = 1'b0;
		i_rx = 1'b0; // shorter than half a bit.
		repeat (GLITCH_CLKS) @(negedge baud_rx_clock);
		i_rx = 1'b1;
		repeat (2 * FRAME_CLKS) begin
			@(negedge baud_rx_clock);
			if (o_rx_valid) seen_valid = 1'b1;
		end
		check_value("glitch_reject valid", 16'h0, seen_valid);
		send_frame(8'h5A, 1'b1);
		expect_word("glitch_reject next", 8'h5A, 1'b0);
		report_test("glitch_reject", fails_before);
	endtask

	task automatic backpressure_overrun();
		logic [7:0] bytes [6];
		int         fails_before;
		fails_before = fail_count;
		i_rx_ready   = 1'b0;
		for (int i = 0; i < 6; i++) begin
			random_byte(bytes[i]);
			send_frame(bytes[i], 1'b1);
		end
		check_value("backpressure_overrun flag", 16'h1, o_overrun);
		for (int i = 0; i < 4; i++) begin
			expect_word("backpressure_overrun drain", bytes[i], 1'b0);
		end
		check_value("backpressure_overrun empty", 16'h0, o_rx_valid);
		report_test("backpressure_overrun", fails_before);
	endtask

	task automatic reset_mid_frame();
		logic [7:0] good;
		int         fails_before;
		fails_before = fail_count;
		// upper data bits and stop are high, so the line is idle after reset.
		fork
			send_frame(8'hF0, 1'b1);
			begin
				repeat (FRAME_CLKS / 2 + BIT_CLKS / 2) @(negedge baud_rx_clock);
				i_reset = 1'b1;
				repeat (8) @(negedge baud_rx_clock);
				i_reset = 1'b0;
			end
		join
		check_value("reset_mid_frame valid", 16'h0, o_rx_valid);
		check_value("reset_mid_frame overrun", 16'h0, o_overrun);
		random_byte(good);
		send_frame(good, 1'b1);
		expect_word("reset_mid_frame next", good, 1'b0);
		report_test("reset_mid_frame", fails_before);
	endtask

	initial begin
		i_reset    = 1'b1;
		i_rx       = 1'b1;
		i_rx_ready = 1'b0;
		repeat (8) @(negedge baud_rx_clock);
		i_reset = 1'b0;
		repeat (4) @(negedge baud_rx_clock);

		single_byte();
		random_stream();
		framing_error();
		glitch_reject();
		backpressure_overrun();
		reset_mid_frame();

		$display("checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- hw/uart_rx_top.sv
`timescale 1ns/1ps

module uart_rx_top (
	input  logic                  baud_rx_clock,
	input  logic                  i_reset,
	input  logic                  i_rx,
	output uart_rx_pkg::rx_word_t o_rx_word,
	output logic                  o_rx_valid,
	input  logic                  i_rx_ready,
	output logic                  o_overrun
);
	import uart_rx_pkg::*;

	logic     tick;
	logic     line;
	logic     start_edge;
	logic     shift_en;
	logic     stop_en;
	logic     push;
	rx_word_t word;

	rx_baud_tick rx_baud_tick_i (
		.baud_rx_clock (baud_rx_clock),
		.i_reset       (i_reset),
		.o_tick        (tick)
	);

	rx_line_sampler rx_line_sampler_i (
		.baud_rx_clock (baud_rx_clock),
		.i_reset       (i_reset),
		.i_rx          (i_rx),
		.i_tick        (tick),
		.o_line        (line),
		.o_start_edge  (start_edge)
	);

	rx_frame_ctrl rx_frame_ctrl_i (
		.baud_rx_clock (baud_rx_clock),
		.i_reset       (i_reset),
		.i_tick        (tick),
		.i_line        (line),
		.i_start_edge  (start_edge),
		.o_shift_en    (shift_en),
		.o_stop_en     (stop_en)
	);

	rx_deserializer rx_deserializer_i (
		.baud_rx_clock (baud_rx_clock),
		.i_reset       (i_reset),
		.i_line        (line),
		.i_shift_en    (shift_en),
		.i_stop_en     (stop_en),
		.o_word        (word),
		.o_push        (push)
	);

	// four bytes of slack for a slow reader.
	rx_fifo #(
		.DEPTH (4)
	) rx_fifo_i (
		.baud_rx_clock (baud_rx_clock),
		.i_reset       (i_reset),
		.i_push        (push),
		.i_word        (word),
		.o_word        (o_rx_word),
		.o_valid       (o_rx_valid),
		.i_ready       (i_rx_ready),
		.o_overrun     (o_overrun)
	);

endmodule

//--- hw/rx_fifo.sv
`timescale 1ns/1ps

module rx_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                  baud_rx_clock,
	input  logic                  i_reset,
	input  logic                  i_push,
	input  uart_rx_pkg::rx_word_t i_word,
	output uart_rx_pkg::rx_word_t o_word,
	output logic                  o_valid,
	input  logic                  i_ready,
	output logic                  o_overrun
);
	import uart_rx_pkg::*;

	rx_word_t                  mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]  rd_ptr;
	logic [$clog2(DEPTH)-1:0]  wr_ptr;
	logic [$clog2(DEPTH):0]    count;
	logic                      full;
	logic                      wr_en;
	logic                      rd_en;

	assign full    = (count == DEPTH);
	assign wr_en   = i_push && !full; // a push into a full buffer is lost.
	assign rd_en   = o_valid && i_ready;
	assign o_valid = (count != '0);
	assign o_word  = mem[rd_ptr];

	always_ff @(posedge baud_rx_clock) begin
		if (wr_en) begin
			mem[wr_ptr] <= i_word;
		end
	end

	always_ff @(posedge baud_rx_clock or posedge i_reset) begin
		if (i_reset) begin
			rd_ptr    <= '0;
			wr_ptr    <= '0;
			count     <= '0;
			o_overrun <= 1'b0;
		end else begin
			if (wr_en) wr_ptr <= wr_ptr + 1'b1;
			if (rd_en) rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (i_push && full) begin
				o_overrun <= 1'b1; // sticky.
			end
		end
	end

	a_count_bound: assert property (@(posedge baud_rx_clock) disable iff (i_reset)
		count <= DEPTH)
		else $error("FIFO count above depth");

	// head entry holds while the reader stalls.
	a_head_hold: assert property (@(posedge baud_rx_clock) disable iff (i_reset)
		o_valid && !i_ready |=> o_valid && $stable(o_word))
		else $error("FIFO head changed under back-pressure");

endmodule

//--- rx_core/rx_deserializer.sv
`timescale 1ns/1ps

module rx_deserializer (
	input  logic                  baud_rx_clock,
	input  logic                  i_reset,
	input  logic                  i_line,
	input  logic                  i_shift_en,
	input  logic                  i_stop_en,
	output uart_rx_pkg::rx_word_t o_word,
	output logic                  o_push
);
	import uart_rx_pkg::*;

	logic [DATA_BITS-1:0] shreg;

	// serial data comes LSB first, so enter at the top and move down.
	always_ff @(posedge baud_rx_clock) begin
		if (i_shift_en) begin
			shreg <= {i_line, shreg[DATA_BITS-1:1]};
		end
		if (i_stop_en) begin
			o_word.data        <= shreg;
			o_word.framing_err <= ~i_line; // stop bit must be high.
		end
	end

	always_ff @(posedge baud_rx_clock or posedge i_reset) begin
		if (i_reset) begin
			o_push <= 1'b0;
		end else begin
			o_push <= i_stop_en; // word is valid alongside.
		end
	end

endmodule

//--- rx_core/rx_frame_ctrl.sv
`timescale 1ns/1ps

module rx_frame_ctrl (
	input  logic baud_rx_clock,
	input  logic i_reset,
	input  logic i_tick,
	input  logic i_line,
	input  logic i_start_edge,
	output logic o_shift_en,
	output logic o_stop_en
);
	import uart_rx_pkg::*;

	rx_state_t  state;
	logic [3:0] tick_cnt;
	logic [2:0] bit_cnt;
	logic       mid_start;
	logic       bit_end;
	logic       start_ok;

	// tick_cnt is cleared on entry to a state, so the n-th tick sees n-1.
	assign mid_start = (state == START) && i_tick && (tick_cnt == 4'(MID_TICK - 1));
	assign bit_end   = i_tick && (tick_cnt == 4'(OVERSAMPLE - 1));
	assign start_ok  = mid_start && !i_line; // still low at mid-start.

	always_ff @(posedge baud_rx_clock or posedge i_reset) begin
		if (i_reset) begin
			state      <= IDLE;
			tick_cnt   <= '0;
			bit_cnt    <= '0;
			o_shift_en <= 1'b0;
			o_stop_en  <= 1'b0;
		end else begin
			o_shift_en <= 1'b0;
			o_stop_en  <= 1'b0;
			case (state)
				IDLE: begin
					if (i_start_edge) begin
						state    <= START;
						tick_cnt <= '0;
					end
				end
				START: begin
					if (mid_start) begin
						// from here on every sample lands mid-bit.
						state    <= start_ok ? DATA : IDLE;
						tick_cnt <= '0;
						bit_cnt  <= '0;
					end else if (i_tick) begin
						tick_cnt <= tick_cnt + 4'd1;
					end
				end
				DATA: begin
					if (bit_end) begin
						o_shift_en <= 1'b1;
						tick_cnt   <= '0;
						if (bit_cnt == 3'(DATA_BITS - 1)) begin
							state <= STOP;
						end else begin
							bit_cnt <= bit_cnt + 3'd1;
						end
					end else if (i_tick) begin
						tick_cnt <= tick_cnt + 4'd1;
					end
				end
				STOP: begin
					if (bit_end) begin
						o_stop_en <= 1'b1;
						tick_cnt  <= '0;
						state     <= IDLE;
					end else if (i_tick) begin
						tick_cnt <= tick_cnt + 4'd1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	a_strobes_exclusive: assert property (@(posedge baud_rx_clock) disable iff (i_reset)
		!(o_shift_en && o_stop_en))
		else $error("shift and stop strobes overlap");

	// an accepted start yields all data shifts before the single stop strobe.
	a_stop_after_data: assert property (@(posedge baud_rx_clock) disable iff (i_reset)
		start_ok |=> (!o_stop_en throughout o_shift_en[->DATA_BITS])
			##1 (!o_shift_en throughout o_stop_en[->1]))
		else $error("stop strobe without a full set of data shifts");

endmodule

//--- hw/rx_line_sampler.sv
`timescale 1ns/1ps

module rx_line_sampler (
	input  logic baud_rx_clock,
	input  logic i_reset,
	input  logic i_rx,
	input  logic i_tick,
	output logic o_line,
	output logic o_start_edge
);
	logic [1:0] sync;
	logic [1:0] hist;
	logic [2:0] hist_next;
	logic       vote;

	// last three samples after this tick, newest sample in bit 0.
	assign hist_next = {hist, sync[1]};

	// two out of three.
	assign vote = (hist_next[0] & hist_next[1]) |
	              (hist_next[0] & hist_next[2]) |
	              (hist_next[1] & hist_next[2]);

	// the pin is asynchronous; idle level is high.
	always_ff @(posedge baud_rx_clock or posedge i_reset) begin
		if (i_reset) begin
			sync <= 2'b11;
		end else begin
			sync <= {sync[0], i_rx};
		end
	end

	always_ff @(posedge baud_rx_clock or posedge i_reset) begin
		if (i_reset) begin
			hist         <= 2'b11;
			o_line       <= 1'b1;
			o_start_edge <= 1'b0;
		end else begin
			o_start_edge <= 1'b0;
			if (i_tick) begin
				hist         <= hist_next[1:0];
				o_line       <= vote;
				o_start_edge <= o_line & ~vote; // voted line falls.
			end
		end
	end

endmodule

//--- hw/rx_baud_tick.sv
`timescale 1ns/1ps

module rx_baud_tick (
	input  logic baud_rx_clock,
	input  logic i_reset,
	output logic o_tick
);
	import uart_rx_pkg::*;

	logic [$clog2(TICK_DIV)-1:0] count;

	// free running divider, one strobe per wrap.
	always_ff @(posedge baud_rx_clock or posedge i_reset) begin
		if (i_reset) begin
			count  <= '0;
			o_tick <= 1'b0;
		end else begin
			if (count == TICK_DIV - 1) begin
				count  <= '0;
				o_tick <= 1'b1;
			end else begin
				count  <= count + 1'b1;
				o_tick <= 1'b0;
			end
		end
	end

	// the strobe lasts one clock and is followed by a gap.
	a_tick_single: assert property (@(posedge baud_rx_clock) disable iff (i_reset)
		o_tick |=> !o_tick)
		else $error("oversample tick held for two cycles");

endmodule

//--- common/uart_rx_pkg.sv
package uart_rx_pkg;

	// line and clock rates for the 8N1 receiver.
	localparam int CLOCK_RATE = 18432000; // system clock in Hz.
	localparam int BAUD_RATE  = 115200;

	// oversampling of each serial bit.
	localparam int OVERSAMPLE = 16;
	localparam int TICK_DIV   = CLOCK_RATE / (BAUD_RATE * OVERSAMPLE); // clocks per tick.
	localparam int MID_TICK   = 8; // tick count at the centre of a bit.

	// frame shape.
	localparam int DATA_BITS = 8;

	// one received byte as it travels into the FIFO.
	// data sits in the low bits, so the word reads as {err, byte}.
	typedef struct packed {
		logic                 framing_err; // stop bit was sampled low.
		logic [DATA_BITS-1:0] data;
	} rx_word_t;

	// frame controller states.
	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} rx_state_t;

endpackage
